//--- design/cart_pkg.sv
// cartridge mapper package
// bus widths, header offsets, mapper kinds and the structs shared between blocks
`default_nettype none

package cart_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------
	localparam int CPU_ADDR_W  = 16;	// cpu address bus
	localparam int DL_ADDR_W   = 25;	// download byte address
	localparam int ROM_WADDR_W = 22;	// external rom, 16 bit words
	localparam int CRAM_ADDR_W = 17;	// 128 KiB cart ram, byte address
	localparam int ROM_BANK_W  = 9;		// up to 512 banks of 16k (mbc5)
	localparam int RAM_BANK_W  = 4;		// up to 16 banks of 8k

	// header words as seen in the download stream (even byte addresses)
	localparam logic [DL_ADDR_W-1:0] HDR_CGB_OFS  = 25'h142;	// cgb flag in high byte
	localparam logic [DL_ADDR_W-1:0] HDR_TYPE_OFS = 25'h146;	// cart type in high byte
	localparam logic [DL_ADDR_W-1:0] HDR_SIZE_OFS = 25'h148;	// {ram size, rom size}

	localparam logic [3:0] RAM_ENABLE_KEY = 4'hA;	// low nibble written to 0000-1fff
	localparam logic [2:0] CRAM_REGION    = 3'b101;	// a000-bfff

	// ----------------------------------------------------------
	// types
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		NONE = 3'd0,	// plain 32k rom
		MBC1 = 3'd1,
		MBC2 = 3'd2,
		MBC3 = 3'd3,
		MBC5 = 3'd4
	} mbc_kind_t;

	// one word of the rom download, 42 bits
	typedef struct packed {
		logic                 wr;
		logic [DL_ADDR_W-1:0] addr;
		logic [15:0]          data;
	} dl_word_t;

	// cpu side of the cartridge slot, 26 bits
	typedef struct packed {
		logic                  rd;
		logic                  wr;
		logic [CPU_ADDR_W-1:0] addr;
		logic [7:0]            wdata;
	} cpu_bus_t;

	// decoded header, 17 bits
	typedef struct packed {
		mbc_kind_t             kind;
		logic [ROM_BANK_W-1:0] rom_mask;
		logic [RAM_BANK_W-1:0] ram_mask;
		logic                  cgb;	// colour game
	} cart_info_t;

	// mapper registers, 16 bits
	typedef struct packed {
		logic [ROM_BANK_W-1:0] rom_bank;
		logic [RAM_BANK_W-1:0] ram_bank;
		logic                  mbc1_mode;	// 1: 4/32 mode, ram banked
		logic                  mbc3_mode;	// 1: rtc mapped at a000
		logic                  ram_en;
	} bank_state_t;

	// power-on register values, also forced during download
	localparam bank_state_t BANK_STATE_RST = '{rom_bank: 9'd1, default: '0};

endpackage

`default_nettype wire

//--- design/cart_header.sv
// cartridge header capture
// picks type, size and cgb bytes out of the rom download and decodes them
`timescale 1ns/100ps
`default_nettype none

module cart_header (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  cart_pkg::dl_word_t   dl_i,
	output cart_pkg::cart_info_t info_o
);
	import cart_pkg::*;

	logic [7:0] type_q;	// 0147
	logic [7:0] rom_size_q;	// 0148
	logic [7:0] ram_size_q;	// 0149
	logic [7:0] cgb_q;	// 0143

	// ----------------------------------------------------------
	// capture
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_q     <= 8'h00;	// kind decodes to NONE
			rom_size_q <= 8'h00;
			ram_size_q <= 8'h00;
			cgb_q      <= 8'h00;
		end else if (dl_i.wr) begin
			case (dl_i.addr)
				HDR_CGB_OFS:  cgb_q  <= dl_i.data[15:8];	// odd byte is high half
				HDR_TYPE_OFS: type_q <= dl_i.data[15:8];
				HDR_SIZE_OFS: begin
					rom_size_q <= dl_i.data[7:0];
					ram_size_q <= dl_i.data[15:8];
				end
				default: ;
			endcase
		end
	end

	// ----------------------------------------------------------
	// decode
	// ----------------------------------------------------------
	always_comb begin
		// mapper kind from cart type byte
		case (type_q)
			8'h01, 8'h02, 8'h03:                      info_o.kind = MBC1;
			8'h05, 8'h06:                             info_o.kind = MBC2;
			8'h0F, 8'h10, 8'h11, 8'h12, 8'h13:        info_o.kind = MBC3;
			8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1E: info_o.kind = MBC5;
			default:                                  info_o.kind = NONE;	// also mmm01, huc etc
		endcase

		// rom: 2 banks at size 0, doubling up to 512 banks at size 8
		if (rom_size_q <= 8'd8)
			info_o.rom_mask = ~(9'h1FF << (rom_size_q[3:0] + 4'd1));
		else
			info_o.rom_mask = 9'h07F;	// odd 72/80/96 bank carts

		// ram: 8k or less is one bank, 32k four, else sixteen
		if (ram_size_q <= 8'd2)
			info_o.ram_mask = 4'h0;
		else if (ram_size_q == 8'd3)
			info_o.ram_mask = 4'h3;
		else
			info_o.ram_mask = 4'hF;

		info_o.cgb = (cgb_q == 8'h80) || (cgb_q == 8'hC0);	// cgb enhanced or cgb only
	end

endmodule

`default_nettype wire

//--- design/mbc_regs.sv
// mapper control registers
// cpu stores into 0000-7fff set ram enable, rom/ram bank and mode bits
`timescale 1ns/100ps
`default_nettype none

module mbc_regs (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire                   dl_active_i,
	input  cart_pkg::cpu_bus_t    cpu_i,
	input  cart_pkg::cart_info_t  info_i,
	output cart_pkg::bank_state_t bank_o
);
	import cart_pkg::*;

	bank_state_t bank_q;
	logic        rom_wr;	// cpu store anywhere in 0000-7fff
	logic [1:0]  reg_sel;	// which 8k window

	assign rom_wr  = cpu_i.wr && !cpu_i.addr[15];
	assign reg_sel = cpu_i.addr[14:13];

	// ----------------------------------------------------------
	// register file
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active_i) begin
			bank_q <= BANK_STATE_RST;	// bank 1 in 4000-7fff, ram off
		end else if (rom_wr) begin
			case (reg_sel)
				// 0000-1fff ram enable
				2'b00: bank_q.ram_en <= (cpu_i.wdata[3:0] == RAM_ENABLE_KEY);

				// 2000-3fff rom bank
				2'b01: begin
					if (info_i.kind == MBC5) begin
						if (cpu_i.addr[12])
							bank_q.rom_bank[8] <= cpu_i.wdata[0];	// 3000-3fff high bit
						else
							bank_q.rom_bank[7:0] <= cpu_i.wdata;	// 2000-2fff low byte
					end else if (cpu_i.wdata[6:0] == 7'd0) begin
						bank_q.rom_bank <= 9'd1;	// bank 0 can't be mapped high
					end else begin
						bank_q.rom_bank <= {2'b00, cpu_i.wdata[6:0]};
					end
				end

				// 4000-5fff ram bank, or rtc select on mbc3
				2'b10: begin
					case (info_i.kind)
						MBC3: begin
							if (cpu_i.wdata[3]) begin
								bank_q.mbc3_mode <= 1'b1;	// rtc register
							end else begin
								bank_q.mbc3_mode <= 1'b0;
								bank_q.ram_bank  <= {2'b00, cpu_i.wdata[1:0]};
							end
						end
						MBC5:    bank_q.ram_bank <= cpu_i.wdata[3:0];
						default: bank_q.ram_bank <= {2'b00, cpu_i.wdata[1:0]};
					endcase
				end

				// 6000-7fff banking mode, mbc1 only
				2'b11: begin
					if (info_i.kind == MBC1)
						bank_q.mbc1_mode <= cpu_i.wdata[0];
				end

				default: ;
			endcase
		end
	end

	assign bank_o = bank_q;

endmodule

`default_nettype wire

//--- design/bank_map.sv
// bank address generation
// banked rom word address and cart ram byte address from cpu address and mapper state
`timescale 1ns/100ps
`default_nettype none

module bank_map (
	input  cart_pkg::cpu_bus_t                 cpu_i,
	input  cart_pkg::cart_info_t               info_i,
	input  cart_pkg::bank_state_t              bank_i,
	output logic [cart_pkg::ROM_WADDR_W-1:0]   rom_addr_o,
	output logic                               rom_rd_o,
	output logic [cart_pkg::CRAM_ADDR_W-1:0]   cram_addr_o
);
	import cart_pkg::*;

	logic [ROM_BANK_W-1:0] rom_bank_raw;	// before mirroring
	logic [ROM_BANK_W-1:0] rom_bank;
	logic [RAM_BANK_W-1:0] ram_bank;
	logic [1:0]            mbc1_hi;	// upper rom lines in mode 0
	logic                  is_cram;

	assign is_cram = (cpu_i.addr[15:13] == CRAM_REGION);

	// ----------------------------------------------------------
	// rom bank
	// ----------------------------------------------------------
	always_comb begin
		// mbc1 mode 0: 2 bit ram register doubles as rom bank bits 6:5
		mbc1_hi = bank_i.mbc1_mode ? 2'b00 : bank_i.ram_bank[1:0];

		case (info_i.kind)
			MBC1:    rom_bank_raw = {2'b00, mbc1_hi, bank_i.rom_bank[4:0]};
			NONE:    rom_bank_raw = {{(ROM_BANK_W-1){1'b0}}, cpu_i.addr[14]};	// 32k linear
			default: rom_bank_raw = bank_i.rom_bank;
		endcase

		if (cpu_i.addr[15:14] != 2'b01)
			rom_bank = '0;	// fixed bank 0 at 0000-3fff
		else if (info_i.kind == NONE)
			rom_bank = rom_bank_raw;
		else
			rom_bank = rom_bank_raw & info_i.rom_mask;	// mirror into rom size
	end

	assign rom_addr_o = {rom_bank, cpu_i.addr[13:1]};	// word address, a0 picks byte
	assign rom_rd_o   = cpu_i.rd && !is_cram;

	// ----------------------------------------------------------
	// cart ram bank
	// ----------------------------------------------------------
	always_comb begin
		if (info_i.kind == MBC1 && !bank_i.mbc1_mode)
			ram_bank = '0;	// mode 0 leaves ram unbanked
		else
			ram_bank = bank_i.ram_bank & info_i.ram_mask;
	end

	assign cram_addr_o = {ram_bank, cpu_i.addr[12:0]};

endmodule

`default_nettype wire

//--- design/cart_ram.sv
// cartridge ram, 128 KiB
// byte writes from the cpu, registered read with enable/rtc/mbc2 masking
`timescale 1ns/100ps
`default_nettype none

module cart_ram (
	input  wire                               clk_sys,
	input  cart_pkg::cpu_bus_t                cpu_i,
	input  wire [cart_pkg::CRAM_ADDR_W-1:0]   cram_addr_i,
	input  cart_pkg::cart_info_t              info_i,
	input  cart_pkg::bank_state_t             bank_i,
	output logic [7:0]                        q_o,
	output logic                              sel_o
);
	import cart_pkg::*;

	logic [7:0] mem [0:(2**CRAM_ADDR_W)-1];	// 16 banks x 8k
	logic [7:0] rd_q;	// raw array output
	logic       off_q;	// ram disabled at read time
	logic       rtc_q;	// mbc3 rtc selected
	logic       nib_q;	// mbc2 4 bit ram
	logic       is_cram;

	assign is_cram = (cpu_i.addr[15:13] == CRAM_REGION);

	// ----------------------------------------------------------
	// array
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (cpu_i.wr && is_cram && bank_i.ram_en)
			mem[cram_addr_i] <= cpu_i.wdata;
		rd_q <= mem[cram_addr_i];	// read every cycle, top picks the valid one
	end

	// masking conditions sampled alongside the data
	always_ff @(posedge clk_sys) begin
		off_q <= !bank_i.ram_en;
		rtc_q <= bank_i.mbc3_mode;
		nib_q <= (info_i.kind == MBC2);
		if (cpu_i.rd)
			sel_o <= is_cram;	// last read came from a000-bfff
	end

	// ----------------------------------------------------------
	// output gating, in priority order
	// ----------------------------------------------------------
	always_comb begin
		if (off_q)
			q_o = 8'hFF;	// open bus
		else if (rtc_q)
			q_o = 8'h00;	// no rtc registers here
		else if (nib_q)
			q_o = {4'hF, rd_q[3:0]};	// upper nibble floats high
		else
			q_o = rd_q;
	end

endmodule

`default_nettype wire

//--- design/cart_top.sv
// cartridge mapper top
// header decode, mapper registers, bank mapping and cart ram, plus the cpu read byte
`timescale 1ns/100ps
`default_nettype none

module cart_top (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  cart_pkg::dl_word_t              dl_i,
	input  wire                             dl_active_i,
	input  cart_pkg::cpu_bus_t              cpu_i,
	input  wire [15:0]                      rom_data_i,
	output logic [cart_pkg::ROM_WADDR_W-1:0] rom_addr_o,
	output logic                            rom_rd_o,
	output logic [7:0]                      cart_do_o
);
	import cart_pkg::*;

	cart_info_t             info;
	bank_state_t            bank;
	logic [CRAM_ADDR_W-1:0] cram_addr;
	logic [7:0]             ram_q;
	logic                   ram_sel;

	logic        dl_active_q;	// for the end-of-download edge
	logic        ready_q;	// a cartridge has been loaded
	logic        a0_q;	// byte select of the read
	logic        rd_q;	// read issued last cycle
	logic [15:0] rom_word_q;
	logic [7:0]  rd_byte;	// byte of the read issued last cycle
	logic [7:0]  hold_q;	// last returned byte

	// ----------------------------------------------------------
	// blocks
	// ----------------------------------------------------------
	cart_header i_header (.clk_sys, .reset, .dl_i, .info_o(info));

	mbc_regs i_regs (.clk_sys, .reset, .dl_active_i, .cpu_i, .info_i(info), .bank_o(bank));

	bank_map i_map (
		.cpu_i, .info_i(info), .bank_i(bank),
		.rom_addr_o, .rom_rd_o, .cram_addr_o(cram_addr)
	);

	cart_ram i_cram (
		.clk_sys, .cpu_i, .cram_addr_i(cram_addr), .info_i(info), .bank_i(bank),
		.q_o(ram_q), .sel_o(ram_sel)
	);

	// ----------------------------------------------------------
	// read return
	// ----------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			ready_q     <= 1'b0;
			a0_q        <= 1'b0;
			rd_q        <= 1'b0;
			hold_q      <= 8'h00;
		end else begin
			dl_active_q <= dl_active_i;
			if (dl_active_q && !dl_active_i)
				ready_q <= 1'b1;	// download finished
			rd_q <= cpu_i.rd;
			if (cpu_i.rd)
				a0_q <= cpu_i.addr[0];
			if (rd_q)
				hold_q <= rd_byte;
		end
	end

	// zero latency memory, sample the word with its address
	always_ff @(posedge clk_sys) begin
		if (rom_rd_o)
			rom_word_q <= rom_data_i;
	end

	assign rd_byte = ram_sel ? ram_q : (a0_q ? rom_word_q[15:8] : rom_word_q[7:0]);

	assign cart_do_o = !ready_q ? 8'h00 : (rd_q ? rd_byte : hold_q);	// nothing before load

endmodule

`default_nettype wire

//--- test/tb_cart_top.sv
// testbench for the cartridge mapper top
// replays the pattern file and checks read bytes and banked rom addresses
`timescale 1ns/100ps
`default_nettype none

module tb_cart_top;
	import cart_pkg::*;

	// one line of the pattern file
	typedef struct packed {
		logic [7:0]      op;
		logic [15:0]     addr;
		logic [15:0]     data;
		logic [23:0]     exp_v;
		logic [8*24-1:0] name;	// T lines only
	} pattern_t;

	logic                   clk_sys;
	logic                   reset;
	dl_word_t               dl;
	logic                   dl_active;
	cpu_bus_t               cpu;
	logic [15:0]            rom_data;
	logic [ROM_WADDR_W-1:0] rom_addr;
	logic                   rom_rd;
	logic [7:0]             cart_do;

	pattern_t        pats[$];
	int              limit_cycles = 0;	// watchdog arms once nonzero
	int              checks = 0;
	int              errors = 0;	// whole run
	int              test_errors = 0;
	int              tests_run = 0;
	int              tests_failed = 0;
	logic [8*24-1:0] test_name = "reset_state";

	cart_top i_dut (
		.clk_sys, .reset, .dl_i(dl), .dl_active_i(dl_active), .cpu_i(cpu),
		.rom_data_i(rom_data), .rom_addr_o(rom_addr), .rom_rd_o(rom_rd), .cart_do_o(cart_do)
	);

	// zero latency rom whose words are their own address scrambled
	assign rom_data = rom_addr[15:0] ^ 16'hA5A5;

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;	// 125 MHz
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;	// drive just after the edge
	endtask

	task automatic load_patterns();
		int               fd;
		int               n;
		logic [7:0]       op;
		logic [15:0]      addr;
		logic [15:0]      data;
		logic [23:0]      exp_v;
		logic [8*24-1:0]  nm;
		logic [8*128-1:0] junk;
		pattern_t         p;
		fd = $fopen("test/cart_patterns.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, " %c", op);
				if (n == 1) begin
					p = '0;
					p.op = op;
					case (op)
						"#": n = $fgets(junk, fd);	// rest of a comment line
						"T": begin
							n = $fscanf(fd, " %s", nm);
							p.name = nm;
						end
						"S", "E": ;
						"D", "W": begin
							n = $fscanf(fd, " %h %h", addr, data);	// no expect column
							p.addr = addr;
							p.data = data;
						end
						default: begin
							n = $fscanf(fd, " %h %h %h", addr, data, exp_v);
							p.addr  = addr;
							p.data  = data;
							p.exp_v = exp_v;
						end
					endcase
					if (op != "#")
						pats.push_back(p);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic check_value(input string sig, input logic [23:0] got,
			input logic [23:0] exp_v);
		checks++;
		assert (got === exp_v)
		else begin
			$display("Error: %0.1f ns %s got %0h expected %0h", $realtime, sig, got, exp_v);
			test_errors++;
		end
	endtask

	task automatic close_test();
		tests_run++;
		errors += test_errors;
		if (test_errors == 0) begin
			$display("test %0s: ok", test_name);
		end else begin
			$display("test %0s: %0d errors", test_name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	// ----------------------------------------------------------
	// each pattern line ends just after a rising edge
	// ----------------------------------------------------------
	task automatic run_op(input pattern_t p);
		case (p.op)
			"T": begin
				close_test();
				test_name = p.name;
			end
			"S": begin
				dl_active = 1'b1;	// holds mapper regs at reset values
				next_cycle();
			end
			"E": begin
				dl_active = 1'b0;	// ready follows on the next edge
				next_cycle();
			end
			"D": begin
				dl.wr   = 1'b1;
				dl.addr = {{(DL_ADDR_W-16){1'b0}}, p.addr};
				dl.data = p.data;
				next_cycle();
				dl.wr = 1'b0;
			end
			"W": begin
				cpu.wr    = 1'b1;
				cpu.addr  = p.addr;
				cpu.wdata = p.data[7:0];
				next_cycle();
				cpu.wr = 1'b0;
			end
			"R": begin
				cpu.rd   = 1'b1;
				cpu.addr = p.addr;
				#2;	// rom strobe only outside a000-bfff
				check_value("rom_rd_o", 24'(rom_rd),
					(p.addr >= 16'hA000 && p.addr < 16'hC000) ? 24'h0 : 24'h1);
				next_cycle();
				cpu.rd = 1'b0;
				check_value("cart_do_o", 24'(cart_do), 24'(p.exp_v[7:0]));	// one cycle later
			end
			"A": begin
				cpu.rd   = 1'b1;
				cpu.addr = p.addr;
				#2;	// combinational path in the same cycle
				check_value("rom_addr_o", 24'(rom_addr), 24'(p.exp_v[ROM_WADDR_W-1:0]));
				check_value("rom_rd_o", 24'(rom_rd), 24'h1);
				next_cycle();
				cpu.rd = 1'b0;
			end
			default: begin
				$display("unknown op '%c' in the pattern file", p.op);
				test_errors++;
			end
		endcase
	endtask

	// ----------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------
	initial begin
		reset     = 1'b1;
		dl        = '0;
		dl_active = 1'b0;
		cpu       = '0;
		load_patterns();
		if (pats.size() == 0) begin
			$display("pattern file test/cart_patterns.txt is missing or empty");
			$display("TESTBENCH FAILED");
			$finish;
		end else begin
			limit_cycles = pats.size() * 4 + 100;
			repeat (5) @(posedge clk_sys);
			#1;
			reset = 1'b0;
			check_value("cart_do_o", 24'(cart_do), 24'h0);
			check_value("rom_rd_o", 24'(rom_rd), 24'h0);
			foreach (pats[i])
				run_op(pats[i]);
			close_test();
			$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
				tests_run, tests_failed, checks, errors);
			if (errors == 0)
				$display("TESTBENCH PASSED");
			else
				$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// watchdog sized from the pattern count
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge clk_sys);
		$display("watchdog: run did not finish within %0d cycles", limit_cycles);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- gb_cart_mapper.f
design/cart_pkg.sv
design/cart_header.sv
design/mbc_regs.sv
design/bank_map.sv
design/cart_ram.sv
design/cart_top.sv
test/tb_cart_top.sv

//--- Makefile
# Verilator flow for the cartridge mapper
VERILATOR ?= verilator
TOP       ?= tb_cart_top
RTL_TOP   ?= cart_top
FILELIST  ?= gb_cart_mapper.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run from the project root, then look for the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/cart_patterns.txt
# op addr data expect: D download word, S/E download start/end, W cpu write,
# R cpu read (expect = cart_do_o), A rom read (expect = rom_addr_o), T test name
T before_after_load
R 0150 00 00
S
D 0146 0100
D 0148 0302
E
R 0150 00 0D
R 0151 00 A5
T mbc1_rom_bank
W 2000 00
A 4000 00 002000
W 2000 05
A 4000 00 00A000
R 4002 00 A4
W 2000 13
A 4000 00 006000
T mbc1_ram_enable
R A000 00 FF
W 0000 0A
W A000 55
R A000 00 55
W 0000 00
R A000 00 FF
T mbc2_ram
S
D 0146 0500
E
W 0000 0A
W A000 3C
R A000 00 FC
T mbc5_banks
S
D 0146 1900
D 0148 0408
E
W 3000 01
W 2000 23
A 4000 00 246000
W 0000 0A
W A000 11
W 4000 09
W A000 99
R A000 00 99
W 4000 00
R A000 00 11
T mbc3_clock_mode
S
D 0146 1300
E
W 0000 0A
W 4000 01
W A000 77
W 4000 08
R A000 00 00
W 4000 01
R A000 00 77
